// ==== issue_pkg.sv ====
// issue stage shared types
`default_nettype none

package issue_pkg;

    // scalar function units
    localparam int NUM_FU   = 3;
    localparam int NUM_REGS = 32;

    // unit indices, a producer tag is index + 1
    localparam int FU_ALU  = 0;
    localparam int FU_LDST = 1;
    localparam int FU_BR   = 2;

    typedef logic [31:0]       word_t;
    typedef logic [4:0]        reg_sel_t;
    // 0 = value ready, otherwise the producing unit + 1
    typedef logic [1:0]        fu_tag_t;
    // saturates at 3
    typedef logic [1:0]        age_t;
    typedef logic [NUM_FU-1:0] fu_vec_t;
    typedef logic [3:0]        op_t;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

    typedef enum logic [1:0] {
        MEM_NA,
        MEM_LOAD,
        MEM_STORE
    } mem_type_e;

    // one instruction as held in a table row
    typedef struct packed {
        reg_sel_t  rd;
        reg_sel_t  rs1;
        reg_sel_t  rs2;
        word_t     imm;
        op_t       op;
        mem_type_e mem_type;
        logic      i_type;
        logic      lui;
    } fust_row_t;

    typedef struct packed {
        logic                      valid;
        logic [$clog2(NUM_FU)-1:0] fu;
        fust_row_t                 row;
        fu_tag_t                   t1;
        fu_tag_t                   t2;
    } dispatch_t;

    typedef struct packed {
        logic     reg_en;
        reg_sel_t reg_sel;
        word_t    wdat;
    } wb_t;

    // record handed to execute
    typedef struct packed {
        fu_vec_t   fu_en;
        reg_sel_t  rd;
        op_t       op;
        mem_type_e mem_type;
        word_t     imm;
        word_t     rdat1;
        word_t     rdat2;
    } issue_t;

endpackage

`default_nettype wire

// ==== regfile.sv ====
// scalar register file
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire logic             CLK,
    input  wire logic             nRST,
    input  wire issue_pkg::wb_t   wb,
    input  wire issue_pkg::reg_sel_t rsel1,
    input  wire issue_pkg::reg_sel_t rsel2,
    output issue_pkg::word_t      rdat1,
    output issue_pkg::word_t      rdat2
);
    import issue_pkg::*;

    word_t regs [NUM_REGS];

    // x0 is never written so it stays at its reset value of zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_en && (wb.reg_sel != '0)) begin
            regs[wb.reg_sel] <= wb.wdat;
        end
    end

    // combinational reads, a same-cycle write is seen next cycle
    always_comb begin
        rdat1 = regs[rsel1];
        rdat2 = regs[rsel2];
    end

endmodule

`default_nettype wire

// ==== fust_table.sv ====
// scalar fust rows and operand tags
`timescale 1ns/100ps
`default_nettype none

module fust_table (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire issue_pkg::dispatch_t   dispatch,
    input  wire issue_pkg::fu_vec_t     fu_done,
    output issue_pkg::fust_row_t [issue_pkg::NUM_FU-1:0] rows,
    output issue_pkg::fu_vec_t          opnd_rdy
);
    import issue_pkg::*;

    fu_tag_t [NUM_FU-1:0] t1_q;
    fu_tag_t [NUM_FU-1:0] t2_q;
    fu_vec_t              load;

    // drop a tag whose producer completes this cycle
    function automatic fu_tag_t clear_tag(fu_tag_t tag, fu_vec_t done);
        fu_tag_t res;
        res = tag;
        if (tag != '0) begin
            if (done[tag - 1'b1]) begin
                res = '0;
            end
        end
        return res;
    endfunction

    // one-hot row select from the dispatch strobe
    assign load = dispatch.valid ? (fu_vec_t'(1) << dispatch.fu) : '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            t1_q <= '0;
            t2_q <= '0;
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                // incoming tags are filtered too, so a done in the dispatch cycle is not lost
                if (load[i]) begin
                    t1_q[i] <= clear_tag(dispatch.t1, fu_done);
                    t2_q[i] <= clear_tag(dispatch.t2, fu_done);
                end else begin
                    t1_q[i] <= clear_tag(t1_q[i], fu_done);
                    t2_q[i] <= clear_tag(t2_q[i], fu_done);
                end
            end
        end
    end

    // instruction fields
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (load[i]) begin
                rows[i] <= dispatch.row;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            opnd_rdy[i] = (t1_q[i] == '0) && (t2_q[i] == '0);
        end
    end

endmodule

`default_nettype wire

// ==== fu_tracker.sv ====
// per-unit fust state machine
`timescale 1ns/100ps
`default_nettype none

module fu_tracker (
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  wire logic                  load,
    input  wire logic                  any_load,
    input  wire logic                  opnd_rdy,
    input  wire logic                  grant,
    input  wire logic                  done,
    input  wire logic                  freeze,
    output issue_pkg::fust_state_e     state,
    output issue_pkg::age_t            age
);
    import issue_pkg::*;

    fust_state_e next_state;
    age_t        next_age;
    logic        done_pend;
    logic        ex_done;

    // a done seen under freeze is held until the stage runs again
    assign ex_done = done || done_pend;

    always_comb begin
        next_state = state;
        next_age   = age;
        if (!freeze) begin
            case (state)
                FUST_EMPTY: begin
                    if (load) begin
                        next_state = FUST_WAIT;
                        next_age   = age_t'(1);
                    end
                end
                FUST_WAIT, FUST_RDY: begin
                    if (state == FUST_WAIT && opnd_rdy) begin
                        next_state = FUST_RDY;
                    end
                    if (state == FUST_RDY && grant) begin
                        next_state = FUST_EX;
                    end
                    // younger dispatch ages every waiting row, saturating
                    if (any_load && (age != '1)) begin
                        next_age = age + 1'b1;
                    end
                end
                FUST_EX: begin
                    if (ex_done) begin
                        next_state = FUST_EMPTY;
                        next_age   = '0;
                    end
                end
                default: next_state = FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= FUST_EMPTY;
            age       <= '0;
            done_pend <= 1'b0;
        end else begin
            state     <= next_state;
            age       <= next_age;
            done_pend <= freeze ? ex_done : 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== issue_select.sv ====
// oldest-ready issue arbiter
`timescale 1ns/100ps
`default_nettype none

module issue_select (
    input  wire issue_pkg::fust_state_e [issue_pkg::NUM_FU-1:0] states,
    input  wire issue_pkg::age_t        [issue_pkg::NUM_FU-1:0] ages,
    input  wire logic                   freeze,
    output issue_pkg::fu_vec_t          grant
);
    import issue_pkg::*;

    logic win;

    // one read port pair, so one grant per cycle
    always_comb begin
        grant = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            win = (states[i] == FUST_RDY);
            for (int j = 0; j < NUM_FU; j++) begin
                if ((j != i) && (states[j] == FUST_RDY)) begin
                    // older row wins
                    // lower index breaks a tie once ages saturate
                    if ((ages[j] > ages[i]) || ((ages[j] == ages[i]) && (j < i))) begin
                        win = 1'b0;
                    end
                end
            end
            grant[i] = win && !freeze;
        end
    end

endmodule

`default_nettype wire

// ==== operand_read.sv ====
// operand fetch and issue register
`timescale 1ns/100ps
`default_nettype none

module operand_read (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire issue_pkg::fu_vec_t     grant,
    input  wire issue_pkg::fust_row_t [issue_pkg::NUM_FU-1:0] rows,
    input  wire logic                   freeze,
    output issue_pkg::reg_sel_t         rsel1,
    output issue_pkg::reg_sel_t         rsel2,
    input  wire issue_pkg::word_t       rdat1,
    input  wire issue_pkg::word_t       rdat2,
    output issue_pkg::issue_t           issue_out
);
    import issue_pkg::*;

    fust_row_t sel_row;
    issue_t    rec;
    logic      use_imm;

    // grant is one-hot, so at most one row is picked
    always_comb begin
        sel_row = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (grant[i]) begin
                sel_row = rows[i];
            end
        end
    end

    assign rsel1 = sel_row.rs1;
    assign rsel2 = sel_row.rs2;

    // loads, stores and branches keep rs2 even with an immediate
    assign use_imm = sel_row.i_type && (sel_row.mem_type == MEM_NA) && !grant[FU_BR];

    always_comb begin
        rec = '0;
        if (|grant) begin
            rec.fu_en    = grant;
            rec.rd       = sel_row.rd;
            rec.op       = sel_row.op;
            rec.mem_type = sel_row.mem_type;
            rec.imm      = sel_row.imm;
            // lui adds the immediate to zero
            rec.rdat1    = sel_row.lui ? '0 : rdat1;
            rec.rdat2    = use_imm ? sel_row.imm : rdat2;
        end
    end

    // empty record when nothing is granted, held while frozen
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_out <= '0;
        end else if (!freeze) begin
            issue_out <= rec;
        end
    end

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
// scoreboard issue stage top
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  wire issue_pkg::dispatch_t  dispatch,
    input  wire issue_pkg::fu_vec_t    fu_done,
    input  wire issue_pkg::wb_t        wb,
    input  wire logic                  freeze,
    output issue_pkg::fu_vec_t         busy,
    output issue_pkg::issue_t          issue_out
);
    import issue_pkg::*;

    fust_row_t   [NUM_FU-1:0] rows;
    fust_state_e [NUM_FU-1:0] states;
    age_t        [NUM_FU-1:0] ages;
    fu_vec_t                  opnd_rdy;
    fu_vec_t                  grant;
    fu_vec_t                  load;
    reg_sel_t                 rsel1;
    reg_sel_t                 rsel2;
    word_t                    rdat1;
    word_t                    rdat2;

    // dispatch strobe steered to its unit
    assign load = dispatch.valid ? (fu_vec_t'(1) << dispatch.fu) : '0;

    fust_table u_table (
        .CLK(CLK), .nRST(nRST), .dispatch(dispatch), .fu_done(fu_done),
        .rows(rows), .opnd_rdy(opnd_rdy)
    );

    for (genvar i = 0; i < NUM_FU; i++) begin : g_tracker
        fu_tracker u_tracker (
            .CLK(CLK), .nRST(nRST), .load(load[i]), .any_load(dispatch.valid),
            .opnd_rdy(opnd_rdy[i]), .grant(grant[i]), .done(fu_done[i]),
            .freeze(freeze), .state(states[i]), .age(ages[i])
        );
        // unit occupied in any state but EMPTY
        assign busy[i] = (states[i] != FUST_EMPTY);
    end

    issue_select u_select (
        .states(states), .ages(ages), .freeze(freeze), .grant(grant)
    );

    operand_read u_opnd (
        .CLK(CLK), .nRST(nRST), .grant(grant), .rows(rows), .freeze(freeze),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2),
        .issue_out(issue_out)
    );

    regfile u_rf (
        .CLK(CLK), .nRST(nRST), .wb(wb), .rsel1(rsel1), .rsel2(rsel2),
        .rdat1(rdat1), .rdat2(rdat2)
    );

endmodule

`default_nettype wire

// ==== issue_tb.sv ====
// issue stage directed testbench
`timescale 1ns/100ps
`default_nettype none

module issue_tb;
    import issue_pkg::*;

    // the tests take about 900 ns and the limit leaves margin
    localparam int TIMEOUT_NS = 2000;

    logic        CLK;
    logic        nRST;
    dispatch_t   dispatch;
    fu_vec_t     fu_done;
    wb_t         wb;
    logic        freeze;
    fu_vec_t     busy;
    issue_t      issue_out;

    word_t       model_regs [NUM_REGS];
    string       cur_test;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    issue_stage DUT (
        .CLK(CLK), .nRST(nRST), .dispatch(dispatch), .fu_done(fu_done),
        .wb(wb), .freeze(freeze), .busy(busy), .issue_out(issue_out)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    task automatic check(string what, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // x0 is kept at zero in the model as well
    task automatic write_reg(int idx, word_t val);
        wb.reg_en  = 1'b1;
        wb.reg_sel = reg_sel_t'(idx);
        wb.wdat    = val;
        tick();
        wb.reg_en  = 1'b0;
        if (idx != 0) begin
            model_regs[idx] = val;
        end
    endtask

    function automatic fust_row_t make_row(int rd, int rs1, int rs2, word_t imm, int op,
                                           mem_type_e mem, logic i_type, logic lui);
        fust_row_t r;
        r.rd       = reg_sel_t'(rd);
        r.rs1      = reg_sel_t'(rs1);
        r.rs2      = reg_sel_t'(rs2);
        r.imm      = imm;
        r.op       = op_t'(op);
        r.mem_type = mem;
        r.i_type   = i_type;
        r.lui      = lui;
        return r;
    endfunction

    // expected record from the operand rules
    function automatic issue_t expect_issue(int fu, fust_row_t row);
        issue_t e;
        e          = '0;
        e.fu_en    = fu_vec_t'(1) << fu;
        e.rd       = row.rd;
        e.op       = row.op;
        e.mem_type = row.mem_type;
        e.imm      = row.imm;
        e.rdat1    = row.lui ? '0 : model_regs[row.rs1];
        if (row.i_type && (row.mem_type == MEM_NA) && (fu != FU_BR)) begin
            e.rdat2 = row.imm;
        end else begin
            e.rdat2 = model_regs[row.rs2];
        end
        return e;
    endfunction

    task automatic do_dispatch(int fu, fust_row_t row, int t1, int t2);
        dispatch.valid = 1'b1;
        dispatch.fu    = 2'(fu);
        dispatch.row   = row;
        dispatch.t1    = fu_tag_t'(t1);
        dispatch.t2    = fu_tag_t'(t2);
        tick();
        dispatch.valid = 1'b0;
    endtask

    task automatic pulse_done(fu_vec_t units);
        fu_done = units;
        tick();
        fu_done = '0;
    endtask

    // counts edges until a record shows up
    task automatic wait_issue(output int cycles);
        cycles = 0;
        while ((issue_out.fu_en == '0) && (cycles < 8)) begin
            tick();
            cycles++;
        end
        if (issue_out.fu_en == '0) begin
            $display("%s: no instruction issued within 8 cycles", cur_test);
            errors++;
        end
    endtask

    task automatic check_issue(issue_t exp);
        check("fu_en", 128'(exp.fu_en), 128'(issue_out.fu_en));
        check("rd", 128'(exp.rd), 128'(issue_out.rd));
        check("op", 128'(exp.op), 128'(issue_out.op));
        check("mem_type", 128'(exp.mem_type), 128'(issue_out.mem_type));
        check("imm", 128'(exp.imm), 128'(issue_out.imm));
        check("rdat1", 128'(exp.rdat1), 128'(issue_out.rdat1));
        check("rdat2", 128'(exp.rdat2), 128'(issue_out.rdat2));
    endtask

    // one instruction with ready operands through issue and completion
    task automatic run_single(int fu, fust_row_t row);
        issue_t exp;
        int     cycles;
        exp = expect_issue(fu, row);
        do_dispatch(fu, row, 0, 0);
        wait_issue(cycles);
        check("latency", 128'(2), 128'(cycles));
        check_issue(exp);
        tick();
        check("fu_en after issue", 128'(0), 128'(issue_out.fu_en));
        check("busy in EX", 128'(fu_vec_t'(1) << fu), 128'(busy));
        pulse_done(fu_vec_t'(1) << fu);
        check("busy after done", 128'(0), 128'(busy));
    endtask

    task automatic test_reset();
        begin_test("reset");
        check("busy", 128'(0), 128'(busy));
        check("issue_out", 128'(0), 128'(issue_out));
        end_test();
    endtask

    task automatic test_plain();
        begin_test("plain_issue");
        run_single(FU_ALU, make_row(3, 5, 7, 32'h0, 1, MEM_NA, 1'b0, 1'b0));
        // x0 as a source
        run_single(FU_ALU, make_row(4, 0, 6, 32'h0, 2, MEM_NA, 1'b0, 1'b0));
        end_test();
    endtask

    task automatic test_operands();
        word_t imm_a;
        word_t imm_b;
        imm_a = $urandom;
        imm_b = $urandom;
        begin_test("operand_forms");
        run_single(FU_ALU, make_row(8, 9, 10, imm_a, 3, MEM_NA, 1'b1, 1'b0));
        run_single(FU_ALU, make_row(8, 11, 12, imm_b, 4, MEM_NA, 1'b1, 1'b1));
        run_single(FU_LDST, make_row(2, 13, 14, imm_a, 0, MEM_LOAD, 1'b1, 1'b0));
        run_single(FU_BR, make_row(0, 1, 2, imm_b, 5, MEM_NA, 1'b1, 1'b0));
        end_test();
    endtask

    task automatic test_dependency();
        fust_row_t ld;
        int        cycles;
        ld = make_row(6, 3, 4, 32'h10, 0, MEM_LOAD, 1'b1, 1'b0);
        begin_test("dependency");
        do_dispatch(FU_ALU, make_row(3, 1, 2, 32'h0, 1, MEM_NA, 1'b0, 1'b0), 0, 0);
        wait_issue(cycles);
        // load waits on the ALU result in rs1
        do_dispatch(FU_LDST, ld, FU_ALU + 1, 0);
        repeat (3) begin
            check("no issue while ALU busy", 128'(0), 128'(issue_out.fu_en));
            check("busy", 128'(3'b011), 128'(busy));
            tick();
        end
        pulse_done(fu_vec_t'(1) << FU_ALU);
        wait_issue(cycles);
        check("latency after done", 128'(2), 128'(cycles));
        check_issue(expect_issue(FU_LDST, ld));
        pulse_done(fu_vec_t'(1) << FU_LDST);
        check("busy after done", 128'(0), 128'(busy));
        end_test();
    endtask

    task automatic test_oldest();
        fust_row_t st;
        fust_row_t br;
        int        cycles;
        st = make_row(0, 5, 6, 32'h8, 0, MEM_STORE, 1'b1, 1'b0);
        br = make_row(0, 7, 8, 32'h40, 6, MEM_NA, 1'b1, 1'b0);
        begin_test("oldest_first");
        do_dispatch(FU_ALU, make_row(5, 1, 2, 32'h0, 1, MEM_NA, 1'b0, 1'b0), 0, 0);
        wait_issue(cycles);
        do_dispatch(FU_LDST, st, FU_ALU + 1, 0);
        do_dispatch(FU_BR, br, 0, FU_ALU + 1);
        pulse_done(fu_vec_t'(1) << FU_ALU);
        wait_issue(cycles);
        check_issue(expect_issue(FU_LDST, st));
        tick();
        check_issue(expect_issue(FU_BR, br));
        pulse_done(fu_vec_t'((1 << FU_LDST) | (1 << FU_BR)));
        check("busy after done", 128'(0), 128'(busy));
        // reverse order so the older branch must beat the lower unit index
        do_dispatch(FU_ALU, make_row(5, 1, 2, 32'h0, 1, MEM_NA, 1'b0, 1'b0), 0, 0);
        wait_issue(cycles);
        do_dispatch(FU_BR, br, FU_ALU + 1, 0);
        do_dispatch(FU_LDST, st, 0, FU_ALU + 1);
        pulse_done(fu_vec_t'(1) << FU_ALU);
        wait_issue(cycles);
        check_issue(expect_issue(FU_BR, br));
        tick();
        check_issue(expect_issue(FU_LDST, st));
        pulse_done(fu_vec_t'((1 << FU_LDST) | (1 << FU_BR)));
        check("busy after done", 128'(0), 128'(busy));
        end_test();
    endtask

    task automatic test_freeze();
        fust_row_t alu;
        fust_row_t ld;
        issue_t    held;
        int        cycles;
        alu = make_row(7, 12, 13, 32'h0, 2, MEM_NA, 1'b0, 1'b0);
        ld  = make_row(9, 10, 11, 32'h4, 0, MEM_LOAD, 1'b0, 1'b0);
        begin_test("freeze");
        held = expect_issue(FU_ALU, alu);
        do_dispatch(FU_ALU, alu, 0, 0);
        do_dispatch(FU_LDST, ld, FU_ALU + 1, 0);
        wait_issue(cycles);
        check_issue(held);
        // done arrives while frozen, so the load becomes ready during freeze
        freeze = 1'b1;
        pulse_done(fu_vec_t'(1) << FU_ALU);
        repeat (4) begin
            check("issue_out held", 128'(held), 128'(issue_out));
            check("busy held", 128'(3'b011), 128'(busy));
            tick();
        end
        freeze = 1'b0;
        tick();
        check("busy after thaw", 128'(3'b010), 128'(busy));
        wait_issue(cycles);
        check("cycles after thaw", 128'(1), 128'(cycles));
        check_issue(expect_issue(FU_LDST, ld));
        pulse_done(fu_vec_t'(1) << FU_LDST);
        end_test();
    endtask

    initial begin
        nRST     = 1'b0;
        dispatch = '0;
        fu_done  = '0;
        wb       = '0;
        freeze   = 1'b0;
        errors   = 0;
        void'($urandom(22632));
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
        test_reset();
        // preload through the writeback port while the x0 write is dropped
        write_reg(0, 32'hdead_beef);
        for (int i = 1; i < 16; i++) begin
            write_reg(i, $urandom);
        end
        test_plain();
        test_operands();
        test_dependency();
        test_oldest();
        test_freeze();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
issue_pkg.sv
regfile.sv
fust_table.sv
fu_tracker.sv
issue_select.sv
operand_read.sv
issue_stage.sv
issue_tb.sv

// ==== Makefile ====
TOP = issue_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, log to sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
